// ==== src/spi_pkg.sv ====
// shared state enums, word width and LFSR rule for the SPI self-test, used by scoped name
package spi_pkg;

    // SPI word width, one byte per transfer
    localparam int BYTE_W = 8;

    // feedback taps on bits 7, 5, 4 and 3
    localparam logic [BYTE_W-1:0] LFSR_TAPS = 8'hB8;

    // PHY sequencing
    typedef enum logic [1:0] {
        PHY_IDLE,                       // cs_n high, waiting for a byte
        PHY_LEAD,                       // cs_n low, sclk low before first rise
        PHY_SHIFT,                      // sixteen sclk half periods
        PHY_TRAIL                       // hold cs_n low after last bit
    } phy_state_t;

    // fixture sequencing
    typedef enum logic [2:0] {
        TEST_IDLE,                      // waiting for run
        TEST_SEND,                      // offer lfsr byte to the PHY
        TEST_WAIT_RX,                   // transfer in flight
        TEST_CHECK,                     // compare echo, step lfsr
        TEST_FINISH                     // result latched, parked here
    } test_state_t;

    // next LFSR value
    // shift left, new bit 0 is the parity of the tapped bits
    function automatic logic [BYTE_W-1:0] lfsr_next(input logic [BYTE_W-1:0] cur);
        logic fb;
        fb = ^(cur & LFSR_TAPS);        // xor of taps
        return {cur[BYTE_W-2:0], fb};
    endfunction

endpackage

// ==== src/spi_phy.sv ====
// SPI mode-0 master PHY shifting one byte per valid/ready handshake with cs_n framing each transfer
`timescale 1ns/1ps

module spi_phy #(
    parameter int CLK_DIV = 2                               // clocks per sclk half period
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        tx_valid,           // byte offered
    input  logic [spi_pkg::BYTE_W-1:0]  tx_data,
    output logic                        tx_ready,           // idle and gap elapsed
    output logic                        rx_valid,           // one-cycle pulse
    output logic [spi_pkg::BYTE_W-1:0]  rx_data,
    output logic                        sclk,
    output logic                        mosi,
    input  logic                        miso,
    output logic                        cs_n
);

    localparam int DIV_W  = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int HALF_W = $clog2(2 * spi_pkg::BYTE_W);
    localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(CLK_DIV - 1);
    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(2 * spi_pkg::BYTE_W - 1);

    spi_pkg::phy_state_t            state;
    logic [DIV_W-1:0]               div_cnt;                // half period timer
    logic [HALF_W-1:0]              half_cnt;               // half periods in shift
    logic [spi_pkg::BYTE_W-1:0]     shreg;                  // tx out, rx in
    logic                           miso_q;                 // bit caught on rising sclk
    logic                           accept;
    logic                           tick;
    logic                           sclk_rise;
    logic                           sclk_fall;

    assign accept = tx_valid && tx_ready;
    assign tick   = (div_cnt == DIV_LAST);                  // end of a half period

    // first rise leaves lead and the rest come from shift with sclk low
    assign sclk_rise = tick && ((state == spi_pkg::PHY_LEAD) ||
                                (state == spi_pkg::PHY_SHIFT && !sclk && half_cnt != HALF_LAST));
    assign sclk_fall = tick && (state == spi_pkg::PHY_SHIFT) && sclk;

    assign mosi    = shreg[spi_pkg::BYTE_W-1];              // msb first
    assign rx_data = shreg;                                 // full rx byte once trail starts

    // half period timer
    // runs during a transfer and through the idle gap after it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (accept || tick) begin
            div_cnt <= '0;
        end else if (state != spi_pkg::PHY_IDLE || !tx_ready) begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // sequencing and pin control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= spi_pkg::PHY_IDLE;
            tx_ready <= 1'b1;
            rx_valid <= 1'b0;
            sclk     <= 1'b0;
            cs_n     <= 1'b1;
            half_cnt <= '0;
        end else begin
            rx_valid <= 1'b0;                               // pulse only
            case (state)
                spi_pkg::PHY_IDLE: begin
                    if (accept) begin
                        state    <= spi_pkg::PHY_LEAD;
                        tx_ready <= 1'b0;
                        cs_n     <= 1'b0;                   // select for this byte
                    end else if (!tx_ready && tick) begin
                        tx_ready <= 1'b1;                   // cs_n high gap done
                    end
                end
                spi_pkg::PHY_LEAD: begin
                    if (tick) begin
                        state    <= spi_pkg::PHY_SHIFT;
                        sclk     <= 1'b1;                   // first rise
                        half_cnt <= '0;
                    end
                end
                spi_pkg::PHY_SHIFT: begin
                    if (tick) begin
                        half_cnt <= half_cnt + 1'b1;
                        if (half_cnt == HALF_LAST) begin
                            state <= spi_pkg::PHY_TRAIL;    // sclk already back low
                        end else begin
                            sclk <= !sclk;
                        end
                    end
                end
                spi_pkg::PHY_TRAIL: begin
                    if (tick) begin
                        state    <= spi_pkg::PHY_IDLE;
                        cs_n     <= 1'b1;                   // deselect
                        rx_valid <= 1'b1;                   // byte ready in shreg
                    end
                end
                default: begin
                    state <= spi_pkg::PHY_IDLE;
                end
            endcase
        end
    end

    // shift register
    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= tx_data;                               // mosi shows bit 7 at once
        end else if (sclk_fall) begin
            shreg <= {shreg[spi_pkg::BYTE_W-2:0], miso_q};  // next mosi bit out
        end
        if (sclk_rise) begin
            miso_q <= miso;                                 // sample on rising sclk
        end
    end

    // no clock outside a selected transfer
    a_sclk_framed: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !sclk);

    a_rx_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

    // no new byte accepted mid transfer
    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !cs_n |-> !tx_ready);

endmodule

// ==== src/spi_phy_test.sv ====
// self-test fixture that sends LFSR bytes through the PHY and checks each echo a transfer later
`timescale 1ns/1ps

module spi_phy_test #(
    parameter int                        NUM_BYTES = 16,    // checked bytes
    parameter logic [spi_pkg::BYTE_W-1:0] SEED     = 8'hA5  // nonzero lfsr start
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        run,                // start, held high
    input  logic                        tx_ready,
    input  logic                        rx_valid,
    input  logic [spi_pkg::BYTE_W-1:0]  rx_data,
    output logic                        tx_valid,
    output logic [spi_pkg::BYTE_W-1:0]  tx_data,
    output logic                        running,
    output logic                        passed
);

    // NUM_BYTES+1 transfers with index 0 .. NUM_BYTES
    localparam int CNT_W = (NUM_BYTES > 0) ? $clog2(NUM_BYTES + 1) : 1;
    localparam logic [CNT_W-1:0] LAST_XFER = CNT_W'(NUM_BYTES);

    spi_pkg::test_state_t           state;
    logic [CNT_W-1:0]               xfer_cnt;               // transfer index
    logic                           mismatch;               // sticky
    logic                           miss_now;
    logic [spi_pkg::BYTE_W-1:0]     lfsr;                   // byte to send
    logic [spi_pkg::BYTE_W-1:0]     prev_byte;              // byte sent last transfer
    logic [spi_pkg::BYTE_W-1:0]     rx_byte;                // captured reply

    assign tx_valid = (state == spi_pkg::TEST_SEND);
    assign tx_data  = lfsr;                                 // steady until check

    // reply of transfer 0 carries nothing useful
    assign miss_now = (xfer_cnt != '0) && (rx_byte != prev_byte);

    // control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= spi_pkg::TEST_IDLE;
            xfer_cnt <= '0;
            mismatch <= 1'b0;
            running  <= 1'b0;
            passed   <= 1'b0;
        end else begin
            case (state)
                spi_pkg::TEST_IDLE: begin
                    if (run) begin
                        state    <= spi_pkg::TEST_SEND;
                        running  <= 1'b1;
                        xfer_cnt <= '0;
                        mismatch <= 1'b0;
                    end
                end
                spi_pkg::TEST_SEND: begin
                    if (tx_ready) begin
                        state <= spi_pkg::TEST_WAIT_RX;     // PHY took the byte
                    end
                end
                spi_pkg::TEST_WAIT_RX: begin
                    if (rx_valid) begin
                        state <= spi_pkg::TEST_CHECK;
                    end
                end
                spi_pkg::TEST_CHECK: begin
                    mismatch <= mismatch || miss_now;
                    xfer_cnt <= xfer_cnt + 1'b1;
                    if (xfer_cnt == LAST_XFER) begin
                        state   <= spi_pkg::TEST_FINISH;
                        running <= 1'b0;
                        passed  <= !(mismatch || miss_now);
                    end else begin
                        state <= spi_pkg::TEST_SEND;
                    end
                end
                spi_pkg::TEST_FINISH: begin
                    state <= spi_pkg::TEST_FINISH;          // parked until reset
                end
                default: begin
                    state <= spi_pkg::TEST_IDLE;
                end
            endcase
        end
    end

    // byte path
    always_ff @(posedge clk) begin
        if (state == spi_pkg::TEST_IDLE && run) begin
            lfsr <= SEED;
        end else if (state == spi_pkg::TEST_CHECK) begin
            lfsr <= spi_pkg::lfsr_next(lfsr);               // next byte to send
        end
        if (state == spi_pkg::TEST_CHECK) begin
            prev_byte <= lfsr;                              // expected in the next reply
        end
        if (state == spi_pkg::TEST_WAIT_RX && rx_valid) begin
            rx_byte <= rx_data;
        end
    end

    // result only shows once the run is over
    a_pass_after_run: assert property (@(posedge clk) disable iff (!rst_n)
        passed |-> !running);

endmodule

// ==== src/spi_selftest_top.sv ====
// board-level top for the SPI PHY self-test, start-up delay then fixture run with LED status
`timescale 1ns/1ps

module spi_selftest_top #(
    parameter int                         CLK_DIV      = 2,     // clocks per sclk half period
    parameter int                         NUM_BYTES    = 16,    // checked bytes
    parameter logic [spi_pkg::BYTE_W-1:0] SEED         = 8'hA5, // lfsr start
    parameter int                         STARTUP_BITS = 6      // start-up delay 2**bits
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    miso,
    output logic    sclk,
    output logic    mosi,
    output logic    cs_n,
    output logic    led_r,                                  // done, failed
    output logic    led_g,                                  // done, passed
    output logic    led_b                                   // test running
);

    logic [STARTUP_BITS-1:0]        waiting;                // start-up count
    logic                           run;
    logic                           tx_valid;
    logic                           tx_ready;
    logic [spi_pkg::BYTE_W-1:0]     tx_data;
    logic                           rx_valid;
    logic [spi_pkg::BYTE_W-1:0]     rx_data;
    logic                           running;
    logic                           passed;
    logic                           running_q;
    logic                           done;

    // start-up delay, run set by counter overflow and then held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {run, waiting} <= '0;
        end else if (!run) begin
            {run, waiting} <= {1'b0, waiting} + 1'b1;
        end
    end

    // done latches on the falling edge of running
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running_q <= 1'b0;
            done      <= 1'b0;
        end else begin
            running_q <= running;
            if (running_q && !running) begin
                done <= 1'b1;
            end
        end
    end

    spi_phy_test #(
        .NUM_BYTES  (NUM_BYTES),
        .SEED       (SEED)
    ) spi_phy_test_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .run        (run),
        .tx_ready   (tx_ready),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .running    (running),
        .passed     (passed)
    );

    spi_phy #(
        .CLK_DIV    (CLK_DIV)
    ) spi_phy_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .tx_ready   (tx_ready),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .sclk       (sclk),
        .mosi       (mosi),
        .miso       (miso),
        .cs_n       (cs_n)
    );

    assign led_b = running;
    assign led_g = done && passed;
    assign led_r = done && !passed;

endmodule

// ==== bench/spi_echo_device.sv ====
// behavioural SPI mode-0 slave for the testbench that replies by fault mode and records mosi bytes
`timescale 1ns/1ps

module spi_echo_device #(
    parameter int MAX_REC = 32                  // bytes kept in the record
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [1:0]  mode,                   // reply rule
    input  int          corrupt_idx,            // transfer whose reply gets bit 0 flipped
    input  logic        sclk,
    input  logic        mosi,
    input  logic        cs_n,
    output logic        miso,
    output logic [7:0]  seen [MAX_REC],         // mosi bytes in order
    output int          seen_cnt                // completed transfers
);

    localparam logic [1:0] MODE_STUCK   = 2'd1;
    localparam logic [1:0] MODE_INVERT  = 2'd2;
    localparam logic [1:0] MODE_CORRUPT = 2'd3;

    logic       miso_r = 1'b0;                  // low from time zero
    logic       sclk_q;                         // pin values one clock back
    logic       cs_q;
    logic [7:0] rx_sr;                          // mosi bits msb first
    logic [7:0] tx_sr;                          // reply bits still to go
    logic [7:0] last_rx;                        // byte of the previous transfer
    logic [7:0] reply;

    // reply for the transfer now starting with index k
    function automatic logic [7:0] reply_byte(input logic [1:0] m, input int k,
                                              input int idx, input logic [7:0] prev);
        case (m)
            MODE_STUCK:   return 8'h00;
            MODE_INVERT:  return ~prev;
            MODE_CORRUPT: return (k == idx) ? (prev ^ 8'h01) : prev;
            default:      return prev;          // mode 0 is plain echo
        endcase
    endfunction

    assign reply = reply_byte(mode, seen_cnt, corrupt_idx, last_rx);
    assign miso  = miso_r;

    // edges found from pin values a clock apart
    always @(posedge clk) begin
        if (!rst_n) begin
            sclk_q   <= 1'b0;
            cs_q     <= 1'b1;
            miso_r   <= 1'b0;
            rx_sr    <= 8'h00;
            tx_sr    <= 8'h00;
            last_rx  <= 8'h00;
            seen_cnt <= 0;
        end else begin
            sclk_q <= sclk;
            cs_q   <= cs_n;
            if (cs_q && !cs_n) begin
                tx_sr  <= reply;                // first bit out on select before first rise
                miso_r <= reply[7];
            end
            if (!cs_n && !sclk_q && sclk) begin
                rx_sr <= {rx_sr[6:0], mosi};    // sample on rising sclk
            end
            if (!cs_n && sclk_q && !sclk) begin
                tx_sr  <= {tx_sr[6:0], 1'b0};
                miso_r <= tx_sr[6];             // next bit after falling sclk
            end
            if (!cs_q && cs_n) begin
                if (seen_cnt < MAX_REC) begin
                    seen[seen_cnt] <= rx_sr;
                end
                seen_cnt <= seen_cnt + 1;
                last_rx  <= rx_sr;              // echoed in the next transfer
            end
        end
    end

endmodule

// ==== bench/tb_spi_selftest.sv ====
// testbench for the SPI self-test top that runs a table of echo fault modes and checks LEDs and bytes
`timescale 1ns/1ps

module tb_spi_selftest;

    localparam int          CLK_DIV        = 2;
    localparam int          NUM_BYTES      = 16;
    localparam logic [7:0]  SEED           = 8'hA5;
    localparam int          STARTUP_BITS   = 6;
    localparam int          STARTUP_CYCLES = 2 ** STARTUP_BITS;
    localparam int          RESET_CYCLES   = 4;
    localparam int          REC_DEPTH      = 32;

    // echo device reply modes
    localparam logic [1:0]  MODE_ECHO    = 2'd0;
    localparam logic [1:0]  MODE_STUCK   = 2'd1;
    localparam logic [1:0]  MODE_INVERT  = 2'd2;
    localparam logic [1:0]  MODE_CORRUPT = 2'd3;

    // one row per run with device mode, corrupted transfer and expected green
    localparam int          NUM_ROWS = 7;
    localparam logic [1:0]  ROW_MODE  [NUM_ROWS] = '{MODE_ECHO, MODE_STUCK, MODE_INVERT,
                                                     MODE_CORRUPT, MODE_CORRUPT,
                                                     MODE_CORRUPT, MODE_CORRUPT};
    localparam int          ROW_INDEX [NUM_ROWS] = '{0, 0, 0, 1, 8, 16, 0};
    localparam logic        ROW_PASS  [NUM_ROWS] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    // per row budget of reset + start-up + 17 transfers of at most 20 half periods + slack
    localparam int CYCLE_LIMIT = NUM_ROWS * (RESET_CYCLES + STARTUP_CYCLES
                                             + (NUM_BYTES + 1) * (20 * CLK_DIV) + 100);

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic [1:0] dev_mode = MODE_ECHO;
    int         dev_corrupt = 0;
    logic       miso;
    logic       sclk;
    logic       mosi;
    logic       cs_n;
    logic       led_r;
    logic       led_g;
    logic       led_b;
    logic [7:0] echo_seen [REC_DEPTH];
    int         echo_cnt;
    logic       cs_prev;
    int         cs_falls;                       // cs_n edges since reset
    int         cs_rises;
    int         cycle_cnt = 0;

    always #5 clk = ~clk;                       // 10 ns period

    spi_selftest_top #(
        .CLK_DIV      (CLK_DIV),
        .NUM_BYTES    (NUM_BYTES),
        .SEED         (SEED),
        .STARTUP_BITS (STARTUP_BITS)
    ) spi_selftest_top_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .miso  (miso),
        .sclk  (sclk),
        .mosi  (mosi),
        .cs_n  (cs_n),
        .led_r (led_r),
        .led_g (led_g),
        .led_b (led_b)
    );

    spi_echo_device #(
        .MAX_REC (REC_DEPTH)
    ) echo_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .mode        (dev_mode),
        .corrupt_idx (dev_corrupt),
        .sclk        (sclk),
        .mosi        (mosi),
        .cs_n        (cs_n),
        .miso        (miso),
        .seen        (echo_seen),
        .seen_cnt    (echo_cnt)
    );

    // chip select framing count
    always @(posedge clk) begin
        if (!rst_n) begin
            cs_prev  <= 1'b1;
            cs_falls <= 0;
            cs_rises <= 0;
        end else begin
            cs_prev <= cs_n;
            if (cs_prev && !cs_n) begin
                cs_falls <= cs_falls + 1;
            end
            if (!cs_prev && cs_n) begin
                cs_rises <= cs_rises + 1;
            end
        end
    end

    // run length guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, the self-test did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // shift left with new bit 0 from taps 7, 5, 4 and 3
    function automatic logic [7:0] lfsr_step(input logic [7:0] cur);
        logic fb;
        fb = cur[7] ^ cur[5] ^ cur[4] ^ cur[3];
        return {cur[6:0], fb};
    endfunction

    function automatic string mode_name(input logic [1:0] m);
        case (m)
            MODE_STUCK:   return "stuck_zero";
            MODE_INVERT:  return "invert";
            MODE_CORRUPT: return "corrupt_at";
            default:      return "echo";
        endcase
    endfunction

    // nothing lit and bus deselected
    task automatic check_quiet(input string phase);
        check_value({phase, ": led_r"}, 32'(led_r), 32'd0);
        check_value({phase, ": led_g"}, 32'(led_g), 32'd0);
        check_value({phase, ": led_b"}, 32'(led_b), 32'd0);
        check_value({phase, ": cs_n"}, 32'(cs_n), 32'd1);
        check_value({phase, ": sclk"}, 32'(sclk), 32'd0);
    endtask

    // recorded mosi bytes against our own LFSR run
    task automatic check_sent_bytes();
        logic [7:0] expect_byte;
        expect_byte = SEED;
        for (int i = 0; i <= NUM_BYTES; i++) begin
            check_value($sformatf("mosi byte %0d", i), 32'(echo_seen[i]), 32'(expect_byte));
            expect_byte = lfsr_step(expect_byte);
        end
    endtask

    task automatic run_row(input int r);
        int wait_cnt;
        $display("row %0d: %s, index %0d", r, mode_name(ROW_MODE[r]), ROW_INDEX[r]);
        @(posedge clk);
        rst_n       <= 1'b0;
        dev_mode    <= ROW_MODE[r];
        dev_corrupt <= ROW_INDEX[r];
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;                  // released after 4 low edges
            end
            @(negedge clk);
            check_quiet("reset");
        end
        wait_cnt = 0;
        @(negedge clk);
        while (!led_b) begin                    // start-up delay
            check_quiet("start-up");
            wait_cnt++;
            @(negedge clk);
        end
        check_value($sformatf("start-up too short (%0d cycles)", wait_cnt),
                    32'(wait_cnt >= STARTUP_CYCLES), 32'd1);
        while (led_b) begin
            check_value("led_g while running", 32'(led_g), 32'd0);
            check_value("led_r while running", 32'(led_r), 32'd0);
            @(negedge clk);
        end
        @(negedge clk);                         // done latches a cycle after led_b falls
        check_value("led_g at end", 32'(led_g), 32'(ROW_PASS[r]));
        check_value("led_r at end", 32'(led_r), 32'(!ROW_PASS[r]));
        check_value("led_b at end", 32'(led_b), 32'd0);
        check_value("cs_n at end", 32'(cs_n), 32'd1);
        check_value("sclk at end", 32'(sclk), 32'd0);
        check_value("cs_n falls", 32'(cs_falls), 32'(NUM_BYTES + 1));
        check_value("cs_n rises", 32'(cs_rises), 32'(NUM_BYTES + 1));
        check_value("bytes recorded", 32'(echo_cnt), 32'(NUM_BYTES + 1));
        check_sent_bytes();
    endtask

    initial begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== compile.f ====
src/spi_pkg.sv
src/spi_phy.sv
src/spi_phy_test.sv
src/spi_selftest_top.sv
bench/spi_echo_device.sv
bench/tb_spi_selftest.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_spi_selftest
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
